//--- design/hamming_macros.svh
`ifndef HAMMING_MACROS_SVH
`define HAMMING_MACROS_SVH

// code geometry of the 128/120 SECDED block
`define HAMMING_DATA_BITS   120
`define HAMMING_CODE_BITS   128
`define HAMMING_PARITY_BITS 8
`define HAMMING_CHECK_BITS  7

// parity window on the encoder side, correction window on the decoder side
`define HAMMING_GAP_CYCLES  8
`define HAMMING_COUNT_W     7

`endif

//--- design/hamming_pkg.sv
package hamming_pkg;

`include "hamming_macros.svh"

    typedef logic [`HAMMING_DATA_BITS-1:0]   data_block_t;
    typedef logic [`HAMMING_CODE_BITS-1:0]   code_block_t;
    typedef logic [`HAMMING_PARITY_BITS-1:0] parity_t;
    typedef logic [`HAMMING_CHECK_BITS-1:0]  check_t;
    typedef logic [`HAMMING_COUNT_W-1:0]     bit_count_t;

    // the first gap of the encoder occurs only once after the start strobe
    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_FIRST_GAP,
        ENC_DATA,
        ENC_PARITY
    } enc_state_t;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_CORRECT,
        DEC_DATA
    } dec_state_t;

endpackage

//--- design/hamming_check_gen.sv
`include "hamming_macros.svh"

module hamming_check_gen
    import hamming_pkg::*;
(
    input  data_block_t data,
    output check_t      check,
    output logic        overall
);

    // code position of a data bit, skipping the powers of two
    function automatic int data_pos(input int idx);
        int pos;
        int seen;
        pos = 2;
        seen = -1;
        while (seen < idx) begin
            pos++;
            if ((pos & (pos - 1)) != 0) begin
                seen++;
            end
        end
        return pos;
    endfunction

    check_t contrib [`HAMMING_DATA_BITS];

    for (genvar i = 0; i < `HAMMING_DATA_BITS; i++) begin : g_bit
        localparam check_t POS = check_t'(data_pos(i));
        assign contrib[i] = POS & {`HAMMING_CHECK_BITS{data[i]}};
    end

    always_comb begin
        check = '0;
        for (int i = 0; i < `HAMMING_DATA_BITS; i++) begin
            check = check ^ contrib[i];
        end
    end

    assign overall = ^{data, check};

endmodule

//--- design/hamming_corrector.sv
`include "hamming_macros.svh"

module hamming_corrector
    import hamming_pkg::*;
(
    input  code_block_t block,
    input  check_t      syndrome,
    input  logic        overall,
    input  logic        enable,
    output data_block_t corrected
);

    localparam check_t     CHECK_ONE = check_t'(1);
    localparam bit_count_t COUNT_ONE = bit_count_t'(1);

    logic       is_data_pos;
    bit_count_t index;

    // zero points at parity bit 7 and a single set bit at a check bit
    assign is_data_pos = syndrome != '0 && (syndrome & (syndrome - CHECK_ONE)) != '0;

    always_comb begin
        bit_count_t below;
        below = '0;
        for (int k = 0; k < `HAMMING_CHECK_BITS; k++) begin
            if ((CHECK_ONE << k) < syndrome) begin
                below = below + COUNT_ONE;
            end
        end
        index = bit_count_t'(syndrome) - below - COUNT_ONE;
    end

    // overall low with a nonzero syndrome is a double error and is left alone
    always_comb begin
        corrected = block[`HAMMING_DATA_BITS-1:0];
        if (enable && overall && is_data_pos) begin
            corrected[index] = ~corrected[index];
        end
    end

endmodule

//--- design/hamming_encoder.sv
`include "hamming_macros.svh"

module hamming_encoder
    import hamming_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic data_in,
    input  logic data_in_valid,
    output logic data_out,
    output logic valid
);

    localparam bit_count_t LAST_DATA = bit_count_t'(`HAMMING_DATA_BITS - 1);
    localparam bit_count_t LAST_GAP  = bit_count_t'(`HAMMING_GAP_CYCLES - 1);
    localparam bit_count_t ONE       = bit_count_t'(1);

    enc_state_t  state;
    bit_count_t  count;
    data_block_t capture;
    data_block_t hold;
    check_t      check;
    logic        overall;
    parity_t     parity;
    logic        taking;

    hamming_check_gen check_gen_i (
        .data    (hold),
        .check   (check),
        .overall (overall)
    );

    assign parity = {overall, check};

    // a nonzero count in idle means the first block is already coming in
    assign taking = (state == ENC_IDLE && (data_in_valid || count != '0)) ||
                    state == ENC_DATA;

    always_ff @(posedge clk) begin
        if (taking) begin
            capture[count] <= data_in;
        end
    end

    // hold changes only in the last gap cycle so the parity stays put while it is sent
    always_ff @(posedge clk) begin
        if ((state == ENC_FIRST_GAP || state == ENC_PARITY) && count == LAST_GAP) begin
            hold <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ENC_DATA) begin
            data_out <= hold[count];
        end else if (state == ENC_PARITY) begin
            data_out <= parity[count[2:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ENC_IDLE;
            count <= '0;
            valid <= 1'b0;
        end else begin
            case (state)
                ENC_IDLE: begin
                    if (taking) begin
                        if (count == LAST_DATA) begin
                            state <= ENC_FIRST_GAP;
                            count <= '0;
                        end else begin
                            count <= count + ONE;
                        end
                    end
                end
                ENC_DATA: begin
                    valid <= 1'b1;
                    if (count == LAST_DATA) begin
                        state <= ENC_PARITY;
                        count <= '0;
                    end else begin
                        count <= count + ONE;
                    end
                end
                ENC_FIRST_GAP, ENC_PARITY: begin
                    if (count == LAST_GAP) begin
                        state <= ENC_DATA;
                        count <= '0;
                    end else begin
                        count <= count + ONE;
                    end
                end
                default: begin
                    state <= ENC_IDLE;
                    count <= '0;
                end
            endcase
        end
    end

endmodule

//--- design/hamming_decoder.sv
`include "hamming_macros.svh"

module hamming_decoder
    import hamming_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic data_in,
    input  logic data_in_valid,
    input  logic ifec_en,
    output logic data_out,
    output logic valid
);

    localparam bit_count_t LAST_CODE  = bit_count_t'(`HAMMING_CODE_BITS - 1);
    localparam bit_count_t LAST_DATA  = bit_count_t'(`HAMMING_DATA_BITS - 1);
    localparam bit_count_t LAST_GAP   = bit_count_t'(`HAMMING_GAP_CYCLES - 1);
    localparam bit_count_t GAP        = bit_count_t'(`HAMMING_GAP_CYCLES);
    localparam bit_count_t SYND_CYCLE = bit_count_t'(1);
    localparam bit_count_t FIX_CYCLE  = bit_count_t'(2);
    localparam bit_count_t ONE        = bit_count_t'(1);

    dec_state_t  state;
    bit_count_t  count;
    code_block_t capture;
    code_block_t hold;
    check_t      gen_check;
    logic        gen_overall;
    check_t      syndrome;
    logic        overall_rx;
    check_t      syndrome_q;
    logic        overall_q;
    logic        fec_en;
    data_block_t corrected;
    logic        taking;

    hamming_check_gen check_gen_i (
        .data    (hold[`HAMMING_DATA_BITS-1:0]),
        .check   (gen_check),
        .overall (gen_overall)
    );

    assign syndrome = gen_check ^ hold[`HAMMING_DATA_BITS +: `HAMMING_CHECK_BITS];

    // the computed check bits cancel out of gen_overall, leaving the parity of the received block
    assign overall_rx = gen_overall ^ (^syndrome) ^ hold[`HAMMING_CODE_BITS-1];

    hamming_corrector corrector_i (
        .block     (hold),
        .syndrome  (syndrome_q),
        .overall   (overall_q),
        .enable    (fec_en),
        .corrected (corrected)
    );

    assign taking = (state == DEC_IDLE && (data_in_valid || count != '0)) ||
                    state == DEC_CORRECT;

    // during data cycles the incoming bits are the tail of the next block
    always_ff @(posedge clk) begin
        if (taking) begin
            capture[count] <= data_in;
        end else if (state == DEC_DATA) begin
            capture[count + GAP] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DEC_CORRECT && count == '0) begin
            hold <= capture;
        end else if (state == DEC_CORRECT && count == FIX_CYCLE) begin
            hold[`HAMMING_DATA_BITS-1:0] <= corrected;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DEC_CORRECT && count == SYND_CYCLE) begin
            syndrome_q <= syndrome;
            overall_q  <= overall_rx;
        end
        if (state == DEC_DATA) begin
            data_out <= hold[count];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= DEC_IDLE;
            count  <= '0;
            valid  <= 1'b0;
            fec_en <= 1'b0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (taking) begin
                        if (count == LAST_CODE) begin
                            state <= DEC_CORRECT;
                            count <= '0;
                        end else begin
                            count <= count + ONE;
                        end
                    end
                end
                DEC_CORRECT: begin
                    valid <= 1'b0;
                    if (count == '0) begin
                        fec_en <= ifec_en;
                    end
                    if (count == LAST_GAP) begin
                        state <= DEC_DATA;
                        count <= '0;
                    end else begin
                        count <= count + ONE;
                    end
                end
                DEC_DATA: begin
                    valid <= 1'b1;
                    if (count == LAST_DATA) begin
                        state <= DEC_CORRECT;
                        count <= '0;
                    end else begin
                        count <= count + ONE;
                    end
                end
                default: begin
                    state <= DEC_IDLE;
                    count <= '0;
                end
            endcase
        end
    end

endmodule

//--- design/hamming_codec_top.sv
module hamming_codec_top (
    input  logic clk,
    input  logic rstn,
    input  logic enc_data_in,
    input  logic enc_data_in_valid,
    input  logic dec_data_in,
    input  logic dec_data_in_valid,
    input  logic dec_ifec_en,
    output logic enc_data_out,
    output logic enc_valid,
    output logic dec_data_out,
    output logic dec_valid
);

    // the two paths share only clock and reset
    hamming_encoder encoder_i (
        .clk           (clk),
        .rstn          (rstn),
        .data_in       (enc_data_in),
        .data_in_valid (enc_data_in_valid),
        .data_out      (enc_data_out),
        .valid         (enc_valid)
    );

    hamming_decoder decoder_i (
        .clk           (clk),
        .rstn          (rstn),
        .data_in       (dec_data_in),
        .data_in_valid (dec_data_in_valid),
        .ifec_en       (dec_ifec_en),
        .data_out      (dec_data_out),
        .valid         (dec_valid)
    );

endmodule

//--- bench/tb_hamming_codec.sv
`include "hamming_macros.svh"

module tb_hamming_codec
    import hamming_pkg::*;
();

    localparam string VECTOR_FILE     = "bench/hamming_vectors.txt";
    localparam int    FILLER_BLOCKS   = 2;
    localparam int    ENC_START_LIMIT = 200;
    localparam int    DEC_START_LIMIT = 400;

    logic clk;
    logic rstn;
    logic enc_data_in;
    logic enc_data_in_valid;
    logic dec_data_in;
    logic dec_data_in_valid;
    logic dec_ifec_en;
    logic enc_data_out;
    logic enc_valid;
    logic dec_data_out;
    logic dec_valid;

    integer      seed = 32'h6726ea9e;
    int          n_vec;
    data_block_t in_blocks[$];
    parity_t     vec_parity[$];
    int          vec_err_a[$];
    int          vec_err_b[$];
    logic        vec_ifec[$];
    data_block_t vec_want[$];

    int          enc_bits;
    int          enc_checked;
    code_block_t enc_word;
    int          dec_bits;
    int          dec_done;
    data_block_t dec_word;

    hamming_codec_top dut_i (
        .clk               (clk),
        .rstn              (rstn),
        .enc_data_in       (enc_data_in),
        .enc_data_in_valid (enc_data_in_valid),
        .dec_data_in       (dec_data_in),
        .dec_data_in_valid (dec_data_in_valid),
        .dec_ifec_en       (dec_ifec_en),
        .enc_data_out      (enc_data_out),
        .enc_valid         (enc_valid),
        .dec_data_out      (dec_data_out),
        .dec_valid         (dec_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_parity(input string name, input parity_t want, input parity_t got);
        if (got !== want) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, want, got));
        end
    endtask

    task automatic check_block(input string name, input data_block_t want,
                               input data_block_t got);
        if (got !== want) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, want, got));
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        data_block_t data;
        int          pos_a;
        int          pos_b;
        int          flag;
        parity_t     parity;
        data_block_t want;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the vector file");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%h %d %d %d %h %h",
                                 data, pos_a, pos_b, flag, parity, want);
                if (fields != 6) begin
                    abort_run($sformatf("malformed vector line: %s", line));
                end
                in_blocks.push_back(data);
                vec_err_a.push_back(pos_a);
                vec_err_b.push_back(pos_b);
                vec_ifec.push_back(flag != 0);
                vec_parity.push_back(parity);
                vec_want.push_back(want);
            end
        end
        $fclose(fd);
        n_vec = in_blocks.size();
        if (n_vec == 0) begin
            abort_run("the vector file holds no vectors");
        end
    endtask

    // filler data is checked at the encoder output only
    task automatic add_filler_blocks();
        logic [127:0] raw;
        for (int i = 0; i < FILLER_BLOCKS; i++) begin
            raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
            in_blocks.push_back(raw[`HAMMING_DATA_BITS-1:0]);
        end
    endtask

    // the encoder takes 120 bits and then ignores 8 cycles, so the period is 128
    task automatic feed_encoder(input int cycle);
        int         blk;
        int         pos;
        bit_count_t idx;
        blk = cycle / `HAMMING_CODE_BITS;
        pos = cycle % `HAMMING_CODE_BITS;
        idx = bit_count_t'(pos);
        enc_data_in_valid <= (cycle == 0);
        if (blk < in_blocks.size() && pos < `HAMMING_DATA_BITS) begin
            enc_data_in <= in_blocks[blk][idx];
        end else begin
            enc_data_in <= 1'b0;
        end
    endtask

    task automatic check_encoded_block(input int blk);
        string name;
        name = $sformatf("encode block %0d", blk);
        if (blk < in_blocks.size()) begin
            check_block({name, " data"}, in_blocks[blk], enc_word[`HAMMING_DATA_BITS-1:0]);
            enc_checked++;
        end
        if (blk < n_vec) begin
            check_parity({name, " parity"}, vec_parity[blk],
                         enc_word[`HAMMING_CODE_BITS-1:`HAMMING_DATA_BITS]);
        end
    endtask

    task automatic forward_encoder_bit();
        int         blk;
        int         pos;
        bit_count_t idx;
        logic       flip;
        if (enc_valid) begin
            blk = enc_bits / `HAMMING_CODE_BITS;
            pos = enc_bits % `HAMMING_CODE_BITS;
            idx = bit_count_t'(pos);
            enc_word[idx] = enc_data_out;
            flip = 1'b0;
            if (blk < n_vec) begin
                flip = (pos + 1 == vec_err_a[blk]) || (pos + 1 == vec_err_b[blk]);
            end
            dec_data_in <= enc_data_out ^ flip;
            dec_data_in_valid <= (enc_bits == 0);
            // the decoder samples the enable one cycle after the last bit of the block
            if (pos == `HAMMING_DATA_BITS) begin
                dec_ifec_en <= (blk < n_vec) ? vec_ifec[blk] : 1'b0;
            end
            if (pos == `HAMMING_CODE_BITS - 1) begin
                check_encoded_block(blk);
            end
            enc_bits++;
        end else if (enc_bits != 0) begin
            abort_run("encoder output valid dropped after the stream had started");
        end
    endtask

    task automatic collect_decoder_bit();
        bit_count_t idx;
        if (dec_valid) begin
            idx = bit_count_t'(dec_bits);
            dec_word[idx] = dec_data_out;
            dec_bits++;
            if (dec_bits == `HAMMING_DATA_BITS) begin
                if (dec_done < n_vec) begin
                    check_block($sformatf("decode block %0d", dec_done),
                                vec_want[dec_done], dec_word);
                end
                dec_done++;
                dec_bits = 0;
            end
        end else if (dec_bits != 0) begin
            abort_run("decoder output valid dropped in the middle of a block");
        end
    endtask

    initial begin
        int cycle_limit;
        rstn = 1'b0;
        enc_data_in = 1'b0;
        enc_data_in_valid = 1'b0;
        dec_data_in = 1'b0;
        dec_data_in_valid = 1'b0;
        dec_ifec_en = 1'b0;
        enc_bits = 0;
        enc_checked = 0;
        dec_bits = 0;
        dec_done = 0;
        load_vectors();
        add_filler_blocks();
        cycle_limit = (n_vec + FILLER_BLOCKS + 1) * `HAMMING_CODE_BITS + DEC_START_LIMIT;

        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        for (int cycle = 0; dec_done < n_vec; cycle++) begin
            if (cycle > cycle_limit) begin
                abort_run("timeout while waiting for the decoded blocks");
            end
            if (enc_bits == 0 && cycle > ENC_START_LIMIT) begin
                abort_run("timeout while waiting for encoder output valid");
            end
            if (dec_done == 0 && dec_bits == 0 && cycle > DEC_START_LIMIT) begin
                abort_run("timeout while waiting for decoder output valid");
            end
            @(posedge clk);
            forward_encoder_bit();
            collect_decoder_bit();
            feed_encoder(cycle);
        end

        if (enc_checked < n_vec) begin
            abort_run("not every vector block was seen at the encoder output");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- bench/hamming_vectors.txt
# data(hex, bit 0 sent first) err_a err_b ifec parity(hex, bit k is parity bit k) decoded(hex)
# error positions are the stream index inside the 128-bit block plus 1, and 0 means none
000000000000000000000000000000 0 0 1 00 000000000000000000000000000000
000000000000000000000000000001 0 0 0 83 000000000000000000000000000001
800000000000000000000000000001 6 0 1 FC 800000000000000000000000000001
00000000000000000000000000000E 65 0 0 04 00000000000001000000000000000E
000000000000000200000000000400 123 0 1 4E 000000000000000200000000000400
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 128 0 1 FF FFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
800000000000000000000000000000 1 2 1 7F 800000000000000000000000000003
000010000000000000000004000010 120 0 1 C4 000010000000000000000004000010
0000000000000000000000000000FF 0 0 0 03 0000000000000000000000000000FF
000000000000000200000000000000 58 0 1 C1 000000000000000200000000000000

//--- src.f
+incdir+design
design/hamming_pkg.sv
design/hamming_check_gen.sv
design/hamming_corrector.sv
design/hamming_encoder.sv
design/hamming_decoder.sv
design/hamming_codec_top.sv
bench/tb_hamming_codec.sv

//--- Makefile
TOP := tb_hamming_codec

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module hamming_codec_top

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
